//--- include/song_rom.svh
`ifndef SONG_ROM_SVH
`define SONG_ROM_SVH

// Song table, indexed by song, voice, address
// Each voice holds eight words, a note index and a length in beats
localparam note_word_t SONG_TABLE [4][3][8] = '{
    '{
        '{'{6'd40, 6'd2}, '{6'd45, 6'd2}, '{6'd50, 6'd2}, '{6'd0, 6'd1},
          '{6'd53, 6'd3}, '{6'd0, 6'd0}, '{6'd0, 6'd0}, '{6'd0, 6'd0}},
        '{'{6'd20, 6'd4}, '{6'd24, 6'd4}, '{6'd30, 6'd4}, '{6'd0, 6'd0},
          '{6'd0, 6'd0}, '{6'd0, 6'd0}, '{6'd0, 6'd0}, '{6'd0, 6'd0}},
        '{'{6'd0, 6'd2}, '{6'd33, 6'd3}, '{6'd36, 6'd3}, '{6'd27, 6'd4},
          '{6'd0, 6'd0}, '{6'd0, 6'd0}, '{6'd0, 6'd0}, '{6'd0, 6'd0}}
    },
    '{
        '{'{6'd48, 6'd1}, '{6'd52, 6'd1}, '{6'd55, 6'd2}, '{6'd48, 6'd2},
          '{6'd43, 6'd2}, '{6'd0, 6'd0}, '{6'd0, 6'd0}, '{6'd0, 6'd0}},
        '{'{6'd24, 6'd2}, '{6'd26, 6'd2}, '{6'd28, 6'd2}, '{6'd31, 6'd2},
          '{6'd0, 6'd0}, '{6'd0, 6'd0}, '{6'd0, 6'd0}, '{6'd0, 6'd0}},
        '{'{6'd60, 6'd3}, '{6'd0, 6'd1}, '{6'd57, 6'd4}, '{6'd0, 6'd0},
          '{6'd0, 6'd0}, '{6'd0, 6'd0}, '{6'd0, 6'd0}, '{6'd0, 6'd0}}
    },
    '{
        '{'{6'd35, 6'd3}, '{6'd38, 6'd3}, '{6'd0, 6'd2}, '{6'd42, 6'd3},
          '{6'd0, 6'd0}, '{6'd0, 6'd0}, '{6'd0, 6'd0}, '{6'd0, 6'd0}},
        '{'{6'd17, 6'd6}, '{6'd21, 6'd6}, '{6'd0, 6'd0}, '{6'd0, 6'd0},
          '{6'd0, 6'd0}, '{6'd0, 6'd0}, '{6'd0, 6'd0}, '{6'd0, 6'd0}},
        '{'{6'd44, 6'd2}, '{6'd46, 6'd2}, '{6'd48, 6'd2}, '{6'd50, 6'd2},
          '{6'd52, 6'd2}, '{6'd54, 6'd2}, '{6'd0, 6'd0}, '{6'd0, 6'd0}}
    },
    '{
        '{'{6'd56, 6'd2}, '{6'd59, 6'd2}, '{6'd62, 6'd2}, '{6'd63, 6'd1},
          '{6'd0, 6'd0}, '{6'd0, 6'd0}, '{6'd0, 6'd0}, '{6'd0, 6'd0}},
        '{'{6'd28, 6'd3}, '{6'd30, 6'd4}, '{6'd0, 6'd0}, '{6'd0, 6'd0},
          '{6'd0, 6'd0}, '{6'd0, 6'd0}, '{6'd0, 6'd0}, '{6'd0, 6'd0}},
        '{'{6'd0, 6'd1}, '{6'd42, 6'd2}, '{6'd45, 6'd2}, '{6'd47, 6'd2},
          '{6'd0, 6'd0}, '{6'd0, 6'd0}, '{6'd0, 6'd0}, '{6'd0, 6'd0}}
    }
};

// Table lookup
// Addresses past the eighth word read as a zero word, which ends voice 0
function automatic note_word_t song_word(input song_t song, input int voice, input addr_t addr);
    if (addr[3] || voice >= NUM_VOICES) begin
        return '0;
    end
    return SONG_TABLE[song][voice][addr[2:0]];
endfunction

`endif

//--- hdl/music_pkg.sv
package music_pkg;

    // Signed audio sample, as handed to the codec
    typedef logic signed [15:0] sample_t;

    // Note index, 0 is a rest
    typedef logic [5:0] note_t;

    // Note length in beats
    // 0 in voice 0 ends the song
    typedef logic [5:0] duration_t;

    // Song number, four songs in the table
    typedef logic [1:0] song_t;

    // Word address inside one voice of a song
    typedef logic [3:0] addr_t;

    // Voice count is fixed by the mixer scaling
    localparam int NUM_VOICES = 3;

    // Phase increment per note index step
    localparam int STEP_SCALE = 64;

    // Peak of one voice's square wave
    localparam sample_t AMPLITUDE = 16'sd8000;

    // One entry of the song table
    typedef struct packed {
        note_t     note;
        duration_t duration;
    } note_word_t;

    // One word per voice, voice 0 in the low bits
    typedef note_word_t [NUM_VOICES-1:0] voice_words_t;

    // One sample per voice
    typedef sample_t [NUM_VOICES-1:0] voice_samples_t;

    // Control unit states
    typedef enum logic [1:0] {STOPPED, PLAYING, NEXT_SONG} mcu_state_e;

endpackage

//--- hdl/mcu.sv
`timescale 1ns/1ps

module mcu import music_pkg::*; (
    input  logic  clk,
    input  logic  arst_n,
    input  logic  play_button,
    input  logic  next_button,
    input  logic  song_done,
    output logic  play,
    output logic  reset_player,
    output song_t song
);

    mcu_state_e state;
    mcu_state_e state_next;
    logic       play_next;
    song_t      song_next;

    // Priority is song end, then next, then play toggle
    always_comb begin
        state_next = state;
        play_next  = play;
        song_next  = song;
        case (state)
            STOPPED, PLAYING: begin
                if (song_done) begin
                    // End of song stops playback and moves on
                    play_next  = 1'b0;
                    song_next  = song + 2'd1;
                    state_next = NEXT_SONG;
                end else if (next_button) begin
                    // Play level carries over to the new song
                    song_next  = song + 2'd1;
                    state_next = NEXT_SONG;
                end else if (play_button) begin
                    play_next  = !play;
                    state_next = play ? STOPPED : PLAYING;
                end
            end
            // One cycle here, the reader restarts at address 0
            NEXT_SONG: state_next = play ? PLAYING : STOPPED;
            default:   state_next = STOPPED;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= STOPPED;
            play  <= 1'b0;
            song  <= '0;
        end else begin
            state <= state_next;
            play  <= play_next;
            song  <= song_next;
        end
    end

    // Reader restart pulse, also the only cycle spent in NEXT_SONG
    assign reset_player = (state == NEXT_SONG);

    // A held play button would toggle play on every cycle
    a_play_pulse: assert property (@(posedge clk) disable iff (!arst_n)
        play_button |=> !play_button);

endmodule

//--- hdl/beat_generator.sv
`timescale 1ns/1ps

module beat_generator #(
    parameter int BEAT_COUNT = 1000
) (
    input  logic clk,
    input  logic arst_n,
    input  logic en,
    output logic beat
);

    // Counter wide enough for BEAT_COUNT-1
    localparam int CNT_W = (BEAT_COUNT > 1) ? $clog2(BEAT_COUNT) : 1;

    logic [CNT_W-1:0] count;
    logic             wrap;

    // Last pulse of a beat period
    assign wrap = (count == CNT_W'(BEAT_COUNT - 1));

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            count <= '0;
        end else if (en) begin
            count <= wrap ? '0 : count + 1'b1;
        end
    end

    // Beat coincides with every BEAT_COUNT-th enable
    assign beat = en && wrap;

    // Each enable is a single sample request
    a_en_pulse: assert property (@(posedge clk) disable iff (!arst_n) en |=> !en);

endmodule

//--- hdl/song_reader.sv
`timescale 1ns/1ps

module song_reader import music_pkg::*; (
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic                  play,
    input  song_t                 song,
    input  logic                  reset_player,
    input  logic [NUM_VOICES-1:0] done_with_note,
    output logic [NUM_VOICES-1:0] load_new_note,
    output voice_words_t          note_words,
    output logic                  song_done
);

    `include "song_rom.svh"

    // Address of the word each voice is playing
    addr_t [NUM_VOICES-1:0] addr;
    // Voice has its current word loaded
    logic [NUM_VOICES-1:0]  started;
    // Song end seen, hold off until the next restart
    logic                   finished;

    addr_t [NUM_VOICES-1:0] fetch_addr;
    voice_words_t           fetch_word;
    logic [NUM_VOICES-1:0]  want_load;
    logic                   end_of_song;

    always_comb begin
        for (int v = 0; v < NUM_VOICES; v++) begin
            // First load uses the held address, later ones step forward
            fetch_addr[v] = started[v] ? addr[v] + 4'd1 : addr[v];
            fetch_word[v] = song_word(song, v, fetch_addr[v]);
            want_load[v]  = play && !finished && (!started[v] || done_with_note[v]);
        end
        // Zero length in voice 0 marks the end
        end_of_song = want_load[0] && (fetch_word[0].duration == '0);
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            addr          <= '0;
            started       <= '0;
            finished      <= 1'b0;
            load_new_note <= '0;
            song_done     <= 1'b0;
        end else begin
            load_new_note <= '0;
            song_done     <= 1'b0;
            if (reset_player) begin
                addr     <= '0;
                started  <= '0;
                finished <= 1'b0;
            end else if (!play) begin
                // Pause keeps addresses, resume reloads the same words
                started <= '0;
            end else if (end_of_song) begin
                finished  <= 1'b1;
                started   <= '0;
                song_done <= 1'b1;
            end else begin
                for (int v = 0; v < NUM_VOICES; v++) begin
                    if (want_load[v]) begin
                        addr[v]          <= fetch_addr[v];
                        started[v]       <= 1'b1;
                        load_new_note[v] <= 1'b1;
                    end
                end
            end
        end
    end

    // Words only matter together with their load strobe
    always_ff @(posedge clk) begin
        for (int v = 0; v < NUM_VOICES; v++) begin
            if (want_load[v]) begin
                note_words[v] <= fetch_word[v];
            end
        end
    end

    // All voices stay quiet after the end of a song until a restart
    a_no_load_after_end: assert property (@(posedge clk) disable iff (!arst_n)
        song_done |=> load_new_note == '0);

endmodule

//--- hdl/note_player.sv
`timescale 1ns/1ps

module note_player import music_pkg::*; (
    input  logic       clk,
    input  logic       arst_n,
    input  logic       play_enable,
    input  note_word_t note_word,
    input  logic       load_new_note,
    input  logic       beat,
    input  logic       generate_next_sample,
    output logic       done_with_note,
    output sample_t    sample_out,
    output logic       new_sample_ready
);

    // Word being played
    note_word_t  word_q;
    // Phase accumulator, top bit picks the half wave
    logic [15:0] phase;
    logic [15:0] phase_step;
    logic [15:0] phase_next;
    duration_t   beat_cnt;
    logic        counting;

    // Pitch grows linearly with the note index
    assign phase_step = 16'(word_q.note * STEP_SCALE);
    assign phase_next = phase + phase_step;

    // Stop counting once the length is reached, a zero length never ends
    assign counting = play_enable && beat && (beat_cnt != word_q.duration);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            word_q           <= '0;
            phase            <= '0;
            beat_cnt         <= '0;
            done_with_note   <= 1'b0;
            new_sample_ready <= 1'b0;
        end else begin
            done_with_note   <= 1'b0;
            new_sample_ready <= generate_next_sample;
            if (load_new_note) begin
                // New note starts at phase 0 with no beats played
                word_q   <= note_word;
                phase    <= '0;
                beat_cnt <= '0;
            end else begin
                if (generate_next_sample && play_enable) begin
                    phase <= phase_next;
                end
                if (counting) begin
                    beat_cnt       <= beat_cnt + 6'd1;
                    done_with_note <= (beat_cnt + 6'd1 == word_q.duration);
                end
            end
        end
    end

    // Square wave sample for the advanced phase
    // Silent on a rest or while paused
    always_ff @(posedge clk) begin
        if (generate_next_sample) begin
            if (!play_enable || word_q.note == '0) begin
                sample_out <= '0;
            end else if (phase_next[15]) begin
                sample_out <= -AMPLITUDE;
            end else begin
                sample_out <= AMPLITUDE;
            end
        end
    end

endmodule

//--- hdl/codec_conditioner.sv
`timescale 1ns/1ps

module codec_conditioner import music_pkg::*; (
    input  logic           clk,
    input  logic           arst_n,
    input  logic           new_frame,
    input  voice_samples_t voice_samples,
    input  logic           latch_new_sample_in,
    output logic           generate_next_sample,
    output sample_t        valid_sample
);

    sample_t mix;
    // Mix waiting for the next frame
    sample_t latched;

    // Each voice scaled by four before the sum, so three voices never overflow
    always_comb begin
        mix = '0;
        for (int i = 0; i < NUM_VOICES; i++) begin
            mix = mix + (sample_t'(voice_samples[i]) >>> 2);
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            generate_next_sample <= 1'b0;
            latched              <= '0;
            valid_sample         <= '0;
        end else begin
            // Request the next sample right after a frame
            generate_next_sample <= new_frame;
            if (latch_new_sample_in) begin
                latched <= mix;
            end
            // Codec sees last frame's mix
            if (new_frame) begin
                valid_sample <= latched;
            end
        end
    end

    // Voices advance once per request
    a_gen_pulse: assert property (@(posedge clk) disable iff (!arst_n)
        generate_next_sample |=> !generate_next_sample);

endmodule

//--- hdl/music_player.sv
`timescale 1ns/1ps

module music_player import music_pkg::*; #(
    // Lower in simulation for shorter beats
    parameter int BEAT_COUNT = 1000
) (
    input  logic    clk,
    input  logic    arst_n,
    input  logic    play_button,
    input  logic    next_button,
    input  logic    new_frame,
    output logic    new_sample_generated,
    output sample_t sample_out
);

    logic                  play;
    logic                  reset_player;
    logic                  song_done;
    logic                  beat;
    song_t                 song;
    logic [NUM_VOICES-1:0] load_new_note;
    logic [NUM_VOICES-1:0] done_with_note;
    logic [NUM_VOICES-1:0] sample_ready;
    voice_words_t          note_words;
    voice_samples_t        voice_samples;

    // Play state and song selection
    mcu i_mcu (
        .clk          (clk),
        .arst_n       (arst_n),
        .play_button  (play_button),
        .next_button  (next_button),
        .song_done    (song_done),
        .play         (play),
        .reset_player (reset_player),
        .song         (song)
    );

    // Only the reader is restarted, voices keep their last word
    song_reader i_song_reader (
        .clk            (clk),
        .arst_n         (arst_n),
        .play           (play),
        .song           (song),
        .reset_player   (reset_player),
        .done_with_note (done_with_note),
        .load_new_note  (load_new_note),
        .note_words     (note_words),
        .song_done      (song_done)
    );

    // Sample request doubles as the beat divider enable
    beat_generator #(
        .BEAT_COUNT (BEAT_COUNT)
    ) i_beat_generator (
        .clk    (clk),
        .arst_n (arst_n),
        .en     (new_sample_generated),
        .beat   (beat)
    );

    for (genvar v = 0; v < NUM_VOICES; v++) begin : g_voice
        note_player i_note_player (
            .clk                  (clk),
            .arst_n               (arst_n),
            .play_enable          (play),
            .note_word            (note_words[v]),
            .load_new_note        (load_new_note[v]),
            .beat                 (beat),
            .generate_next_sample (new_sample_generated),
            .done_with_note       (done_with_note[v]),
            .sample_out           (voice_samples[v]),
            .new_sample_ready     (sample_ready[v])
        );
    end

    // All voices strobe ready in the same cycle
    codec_conditioner i_codec_conditioner (
        .clk                  (clk),
        .arst_n               (arst_n),
        .new_frame            (new_frame),
        .voice_samples        (voice_samples),
        .latch_new_sample_in  (&sample_ready),
        .generate_next_sample (new_sample_generated),
        .valid_sample         (sample_out)
    );

endmodule

//--- tests/tb_clock.sv
`timescale 1ns/1ps

module tb_clock #(
    parameter int HALF_PERIOD  = 5,
    parameter int RESET_CYCLES = 16
) (
    output logic clk,
    output logic arst_n
);

    // Free running clock, 10 ns period by default
    initial begin
        clk = 1'b0;
        forever begin
            #HALF_PERIOD clk = ~clk;
        end
    end

    // Reset held for a fixed number of edges, released just after one
    initial begin
        arst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1 arst_n = 1'b1;
    end

endmodule

//--- tests/tb_music_player.sv
`timescale 1ns/1ps

module tb_music_player import music_pkg::*; ();

    localparam int BEAT_COUNT   = 4;
    localparam int FRAME_CYCLES = 8;
    // Frames per test, the song end wait sized for the longest song
    localparam int PLANNED_FRAMES = 2 + 6 + 24 + 12 + 40 + 58;
    localparam int CYCLE_LIMIT    = PLANNED_FRAMES * FRAME_CYCLES * 12 / 10;

    logic    clk;
    logic    arst_n;
    logic    play_button;
    logic    next_button;
    logic    new_frame;
    logic    new_sample_generated;
    sample_t sample_out;

    // Table guard is already set by the reader, the testbench needs its own copy
    `undef SONG_ROM_SVH
    `include "song_rom.svh"

    // Reference model state, one entry per register stage of the player
    logic                  m_play;
    logic                  m_restart;
    song_t                 m_song;
    logic                  m_song_done;
    logic                  m_song_ended;
    addr_t                 m_addr [NUM_VOICES];
    logic [NUM_VOICES-1:0] m_started;
    logic                  m_finished;
    logic [NUM_VOICES-1:0] m_load;
    note_word_t            m_words [NUM_VOICES];
    note_word_t            m_word [NUM_VOICES];
    logic [15:0]           m_phase [NUM_VOICES];
    int                    m_beats [NUM_VOICES];
    logic [NUM_VOICES-1:0] m_done;
    sample_t               m_voice [NUM_VOICES];
    int                    m_beat_pos;
    logic                  m_gen;
    logic                  m_ready;
    sample_t               m_latched;
    sample_t               m_out;

    logic [31:0] lfsr;
    int          cycle_index;
    int          watchdog = 0;
    int          pass_count = 0;
    int          fail_count = 0;

    tb_clock #(
        .HALF_PERIOD  (5),
        .RESET_CYCLES (16)
    ) i_tb_clock (
        .clk    (clk),
        .arst_n (arst_n)
    );

    music_player #(
        .BEAT_COUNT (BEAT_COUNT)
    ) i_music_player (
        .clk                  (clk),
        .arst_n               (arst_n),
        .play_button          (play_button),
        .next_button          (next_button),
        .new_frame            (new_frame),
        .new_sample_generated (new_sample_generated),
        .sample_out           (sample_out)
    );

    // Galois LFSR, taps for x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    // One LFSR step per bit taken
    function automatic int unsigned random_bits(input int n);
        int unsigned value;
        value = 0;
        for (int i = 0; i < n; i++) begin
            lfsr  = lfsr_step(lfsr);
            value = (value << 1) | lfsr[0];
        end
        return value;
    endfunction

    task automatic check_sample(input string name, input sample_t actual, input sample_t expected);
        if (actual !== expected) begin
            fail_count++;
            $display("Error at %0t ns: %s is %0d, expected %0d", $time, name, actual, expected);
        end else begin
            pass_count++;
        end
    endtask

    task automatic check_strobe(input string name, input logic actual, input logic expected);
        if (actual !== expected) begin
            fail_count++;
            $display("Error at %0t ns: %s is %b, expected %b", $time, name, actual, expected);
        end else begin
            pass_count++;
        end
    endtask

    // Advance the model by one clock edge with the inputs seen at that edge
    task automatic model_step(input logic pb, input logic nb, input logic nf);
        logic                  play_q;
        song_t                 song_q;
        logic                  beat_q;
        logic                  ready_q;
        logic                  sdone_q;
        logic [NUM_VOICES-1:0] want;
        addr_t                 fetch_addr [NUM_VOICES];
        note_word_t            fetch [NUM_VOICES];
        logic                  song_end;
        logic [15:0]           advanced;
        int                    mix;
        play_q  = m_play;
        song_q  = m_song;
        ready_q = m_ready;
        sdone_q = m_song_done;
        // Beat lands on every BEAT_COUNT-th sample request
        beat_q  = m_gen && (m_beat_pos == BEAT_COUNT - 1);
        mix     = 0;
        for (int v = 0; v < NUM_VOICES; v++) begin
            // Each voice divided by four before the sum
            mix           = mix + (int'(m_voice[v]) >>> 2);
            fetch_addr[v] = m_started[v] ? m_addr[v] + 4'd1 : m_addr[v];
            fetch[v]      = song_word(song_q, v, fetch_addr[v]);
            want[v]       = play_q && !m_finished && (!m_started[v] || m_done[v]);
        end
        // Zero length word in voice 0 ends the song
        song_end = want[0] && (fetch[0].duration == 0);

        // Voices, sample from the phase after this step
        for (int v = 0; v < NUM_VOICES; v++) begin
            advanced  = m_phase[v] + 16'(m_word[v].note * STEP_SCALE);
            m_done[v] = 1'b0;
            if (m_gen) begin
                if (!play_q || m_word[v].note == 0) begin
                    m_voice[v] = '0;
                end else begin
                    m_voice[v] = advanced[15] ? -AMPLITUDE : AMPLITUDE;
                end
            end
            if (m_load[v]) begin
                m_word[v]  = m_words[v];
                m_phase[v] = '0;
                m_beats[v] = 0;
            end else begin
                if (m_gen && play_q) begin
                    m_phase[v] = advanced;
                end
                if (play_q && beat_q && m_beats[v] != m_word[v].duration) begin
                    m_beats[v]++;
                    m_done[v] = (m_beats[v] == m_word[v].duration);
                end
            end
        end

        // Reader, restart wins over pause and song end
        m_load      = '0;
        m_song_done = 1'b0;
        if (m_restart) begin
            for (int v = 0; v < NUM_VOICES; v++) begin
                m_addr[v] = '0;
            end
            m_started  = '0;
            m_finished = 1'b0;
        end else if (!play_q) begin
            m_started = '0;
        end else if (song_end) begin
            m_finished  = 1'b1;
            m_started   = '0;
            m_song_done = 1'b1;
        end else begin
            for (int v = 0; v < NUM_VOICES; v++) begin
                if (want[v]) begin
                    m_addr[v]    = fetch_addr[v];
                    m_started[v] = 1'b1;
                    m_load[v]    = 1'b1;
                    m_words[v]   = fetch[v];
                end
            end
        end

        // Control, buttons are ignored in the restart cycle
        if (m_restart) begin
            m_restart = 1'b0;
        end else if (sdone_q) begin
            m_play       = 1'b0;
            m_song       = m_song + 2'd1;
            m_restart    = 1'b1;
            m_song_ended = 1'b1;
        end else if (nb) begin
            m_song    = m_song + 2'd1;
            m_restart = 1'b1;
        end else if (pb) begin
            m_play = !m_play;
        end

        if (m_gen) begin
            m_beat_pos = (m_beat_pos == BEAT_COUNT - 1) ? 0 : m_beat_pos + 1;
        end

        // Output shows the mix from one frame back
        if (nf) begin
            m_out = m_latched;
        end
        if (ready_q) begin
            m_latched = sample_t'(mix);
        end
        m_ready = m_gen;
        m_gen   = nf;
    endtask

    // One clock, inputs for the next edge driven 1 ns after this one
    task automatic tick(input logic pb, input logic nb);
        @(posedge clk);
        model_step(play_button, next_button, new_frame);
        cycle_index++;
        #1;
        play_button = pb;
        next_button = nb;
        new_frame   = (cycle_index % FRAME_CYCLES == 0);
        @(negedge clk);
        check_sample("sample_out", sample_out, m_out);
        check_strobe("new_sample_generated", new_sample_generated, m_gen);
    endtask

    task automatic run_frames(input int frames);
        repeat (frames * FRAME_CYCLES) tick(1'b0, 1'b0);
    endtask

    task automatic press_play();
        tick(1'b1, 1'b0);
    endtask

    task automatic press_next();
        tick(1'b0, 1'b1);
    endtask

    task automatic report_test(input string name, input int errors_before);
        if (fail_count == errors_before) begin
            $display("%s: ok", name);
        end else begin
            $display("%s: %0d mismatches", name, fail_count - errors_before);
        end
    endtask

    // Run limit
    always @(posedge clk) begin
        if (arst_n) begin
            watchdog++;
            if (watchdog > CYCLE_LIMIT) begin
                $display("Timeout: no end of test after %0d cycles", watchdog);
                $display("TB FAILED");
                $finish;
            end
        end
    end

    initial begin
        int errors_before;
        int gap;
        play_button  = 1'b0;
        next_button  = 1'b0;
        new_frame    = 1'b0;
        lfsr         = 32'h4f911c3c;
        cycle_index  = 0;
        // Model starts in its reset state
        m_play       = 1'b0;
        m_restart    = 1'b0;
        m_song       = '0;
        m_song_done  = 1'b0;
        m_song_ended = 1'b0;
        m_started    = '0;
        m_finished   = 1'b0;
        m_load       = '0;
        m_done       = '0;
        m_beat_pos   = 0;
        m_gen        = 1'b0;
        m_ready      = 1'b0;
        m_latched    = '0;
        m_out        = '0;
        for (int v = 0; v < NUM_VOICES; v++) begin
            m_addr[v]  = '0;
            m_words[v] = '0;
            m_word[v]  = '0;
            m_phase[v] = '0;
            m_beats[v] = 0;
            m_voice[v] = '0;
        end
        @(posedge arst_n);

        // Idle after reset, silent output and no strobe before a frame
        errors_before = fail_count;
        run_frames(2);
        check_sample("sample_out", sample_out, '0);
        report_test("Test 1 reset state", errors_before);

        errors_before = fail_count;
        run_frames(6);
        report_test("Test 2 strobe timing", errors_before);

        errors_before = fail_count;
        press_play();
        run_frames(24);
        report_test("Test 3 song 0 playback", errors_before);

        // Pause goes silent within two frames, resume reloads the same words
        errors_before = fail_count;
        press_play();
        run_frames(4);
        check_sample("sample_out", sample_out, '0);
        press_play();
        run_frames(8);
        report_test("Test 4 pause and resume", errors_before);

        // Four presses bring the selection back to song 0
        errors_before = fail_count;
        for (int p = 0; p < 4; p++) begin
            gap = 1 + random_bits(3);
            run_frames(gap);
            repeat (random_bits(3)) tick(1'b0, 1'b0);
            press_next();
        end
        run_frames(4);
        report_test("Test 5 next song", errors_before);

        errors_before = fail_count;
        m_song_ended  = 1'b0;
        while (!m_song_ended) begin
            tick(1'b0, 1'b0);
        end
        run_frames(2);
        check_sample("sample_out", sample_out, '0);
        press_play();
        run_frames(6);
        report_test("Test 6 end of song", errors_before);

        $display("Checks: %0d passed, %0d failed", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

//--- sim.f
+incdir+include
hdl/music_pkg.sv
hdl/mcu.sv
hdl/beat_generator.sv
hdl/song_reader.sv
hdl/note_player.sv
hdl/codec_conditioner.sv
hdl/music_player.sv
tests/tb_clock.sv
tests/tb_music_player.sv

//--- Bender.yml
package:
  name: music_player

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - hdl/music_pkg.sv
      - hdl/mcu.sv
      - hdl/beat_generator.sv
      - hdl/song_reader.sv
      - hdl/note_player.sv
      - hdl/codec_conditioner.sv
      - hdl/music_player.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - tests/tb_clock.sv
      - tests/tb_music_player.sv
